// ==== filelist.f ====
hdl/shell_bus_pkg.sv
hdl/shell_csr_pkg.sv
hdl/shell_csr.sv
hdl/host_apb_arbiter.sv
hdl/dram_window.sv
hdl/zynq_accel_shell.sv
sim/tb_clkgen.sv
sim/tb_zynq_accel_shell.sv

// ==== hdl/dram_window.sv ====
`timescale 1ns/1ps
`default_nettype none

module dram_window (
   input  wire                                    aclk,
   input  wire                                    rst_n_i,
   input  wire                                    accel_rst_n_i,
   input  wire                                    dram_init_i,
   input  wire [shell_bus_pkg::ACCEL_ADDR_W-1:0]  dram_base_i,
   // from the accelerator
   input  wire                                    dram_psel_i,
   input  wire                                    dram_penable_i,
   input  wire                                    dram_pwrite_i,
   input  wire [shell_bus_pkg::ACCEL_ADDR_W-1:0]  dram_paddr_i,
   input  wire [shell_bus_pkg::DATA_W-1:0]        dram_pwdata_i,
   output logic [shell_bus_pkg::DATA_W-1:0]       dram_prdata_o,
   output logic                                   dram_pready_o,
   output logic                                   dram_pslverr_o,
   // to the host dram port
   output logic                                   hp0_psel_o,
   output logic                                   hp0_penable_o,
   output logic                                   hp0_pwrite_o,
   output logic [shell_bus_pkg::ACCEL_ADDR_W-1:0] hp0_paddr_o,
   output logic [shell_bus_pkg::DATA_W-1:0]       hp0_pwdata_o,
   input  wire [shell_bus_pkg::DATA_W-1:0]        hp0_prdata_i,
   input  wire                                    hp0_pready_i,
   input  wire                                    hp0_pslverr_i,
   output logic [shell_bus_pkg::PROFILE_W-1:0]    profile_o
);
   import shell_bus_pkg::*;

   logic                     access;
   logic                     fwd_done;
   logic [PROFILE_IDX_W-1:0] region;
   logic [PROFILE_W-1:0]     profile_r;

   assign access = dram_psel_i & dram_penable_i;

   // strip the accelerator dram base, then move into the allocated block
   assign hp0_psel_o    = dram_psel_i & dram_init_i;
   assign hp0_penable_o = dram_penable_i & dram_init_i;
   assign hp0_pwrite_o  = dram_pwrite_i;
   assign hp0_paddr_o   = (dram_paddr_i ^ ACCEL_DRAM_BASE) + dram_base_i;
   assign hp0_pwdata_o  = dram_pwdata_i;

   // without an allocation every access fails at once
   assign dram_pready_o  = access & (dram_init_i ? hp0_pready_i : 1'b1);
   assign dram_pslverr_o = access & (dram_init_i ? hp0_pslverr_i : 1'b1);
   assign dram_prdata_o  = hp0_prdata_i;

   ////////////////////////////////////////////////////////////////////////////
   // memory profiler
   ////////////////////////////////////////////////////////////////////////////

   assign region   = dram_paddr_i[PROFILE_LSB +: PROFILE_IDX_W];
   assign fwd_done = hp0_psel_o & hp0_penable_o & hp0_pready_i;

   always_ff @(posedge aclk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         profile_r <= '0;
      end else if (!accel_rst_n_i) begin
         profile_r <= '0;
      end else if (fwd_done) begin
         profile_r[region] <= 1'b1;
      end
   end

   assign profile_o = profile_r;

   a_no_hp0_unallocated: assert property (@(posedge aclk) disable iff (!rst_n_i)
      !dram_init_i |-> !hp0_psel_o);

endmodule

`default_nettype wire

// ==== hdl/host_apb_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module host_apb_arbiter (
   input  wire                                    aclk,
   input  wire                                    rst_n_i,
   // gp1 host port
   input  wire                                    gp1_psel_i,
   input  wire                                    gp1_penable_i,
   input  wire                                    gp1_pwrite_i,
   input  wire [shell_bus_pkg::GP1_ADDR_W-1:0]    gp1_paddr_i,
   input  wire [shell_bus_pkg::DATA_W-1:0]        gp1_pwdata_i,
   output logic [shell_bus_pkg::DATA_W-1:0]       gp1_prdata_o,
   output logic                                   gp1_pready_o,
   output logic                                   gp1_pslverr_o,
   // gp2 host port
   input  wire                                    gp2_psel_i,
   input  wire                                    gp2_penable_i,
   input  wire                                    gp2_pwrite_i,
   input  wire [shell_bus_pkg::GP2_ADDR_W-1:0]    gp2_paddr_i,
   input  wire [shell_bus_pkg::DATA_W-1:0]        gp2_pwdata_i,
   output logic [shell_bus_pkg::DATA_W-1:0]       gp2_prdata_o,
   output logic                                   gp2_pready_o,
   output logic                                   gp2_pslverr_o,
   // accelerator bus
   output logic                                   accel_psel_o,
   output logic                                   accel_penable_o,
   output logic                                   accel_pwrite_o,
   output logic [shell_bus_pkg::ACCEL_ADDR_W-1:0] accel_paddr_o,
   output logic [shell_bus_pkg::DATA_W-1:0]       accel_pwdata_o,
   input  wire [shell_bus_pkg::DATA_W-1:0]        accel_prdata_i,
   input  wire                                    accel_pready_i,
   input  wire                                    accel_pslverr_i
);
   import shell_bus_pkg::*;

   arb_state_e              state_r;
   arb_state_e              state_nxt;
   logic                    gnt_gp2_r;
   logic                    pick_gp2;
   logic                    grant;
   logic                    resp;
   logic [ACCEL_ADDR_W-1:0] gp1_xlate;
   logic [ACCEL_ADDR_W-1:0] gp2_xlate;
   logic [ACCEL_ADDR_W-1:0] addr_r;
   logic                    write_r;
   logic [DATA_W-1:0]       wdata_r;
   logic [DATA_W-1:0]       rdata_r;
   logic                    err_r;

   ////////////////////////////////////////////////////////////////////////////
   // address translation
   ////////////////////////////////////////////////////////////////////////////

   // gp1: host 0x0xxx_xxxx lands in dram at 0x8xxx_xxxx, 0x2xxx_xxxx at 0x0xxx_xxxx
   assign gp1_xlate = {~gp1_paddr_i[GP1_ADDR_W-1], 3'b000, gp1_paddr_i[ACCEL_ADDR_W-5:0]};
   assign gp2_xlate = ACCEL_ADDR_W'(gp2_paddr_i);

   // round robin, the host served last loses a tie
   assign pick_gp2 = gp2_psel_i & (~gp1_psel_i | ~gnt_gp2_r);
   assign grant    = (state_r == ARB_IDLE) & (gp1_psel_i | gp2_psel_i);
   assign resp     = (state_r == ARB_RESP);

   always_comb begin
      state_nxt = state_r;
      case (state_r)
         ARB_IDLE:   if (grant) state_nxt = ARB_SETUP;
         ARB_SETUP:  state_nxt = ARB_ACCESS;
         ARB_ACCESS: if (accel_pready_i) state_nxt = ARB_RESP;
         ARB_RESP:   state_nxt = ARB_IDLE;
         default:    state_nxt = ARB_IDLE;
      endcase
   end

   // gnt_gp2_r starts set so gp1 wins the first tie
   always_ff @(posedge aclk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_r   <= ARB_IDLE;
         gnt_gp2_r <= 1'b1;
      end else begin
         state_r <= state_nxt;
         if (grant) begin
            gnt_gp2_r <= pick_gp2;
         end
      end
   end

   // request captured at grant, response captured as the accelerator completes
   always_ff @(posedge aclk) begin
      if (grant) begin
         addr_r  <= pick_gp2 ? gp2_xlate : gp1_xlate;
         write_r <= pick_gp2 ? gp2_pwrite_i : gp1_pwrite_i;
         wdata_r <= pick_gp2 ? gp2_pwdata_i : gp1_pwdata_i;
      end
      if (state_r == ARB_ACCESS && accel_pready_i) begin
         rdata_r <= accel_prdata_i;
         err_r   <= accel_pslverr_i;
      end
   end

   assign accel_psel_o    = (state_r == ARB_SETUP) | (state_r == ARB_ACCESS);
   assign accel_penable_o = (state_r == ARB_ACCESS);
   assign accel_pwrite_o  = write_r;
   assign accel_paddr_o   = addr_r;
   assign accel_pwdata_o  = wdata_r;

   // host completion, one cycle after the accelerator
   assign gp1_pready_o  = resp & ~gnt_gp2_r;
   assign gp2_pready_o  = resp & gnt_gp2_r;
   assign gp1_prdata_o  = gp1_pready_o ? rdata_r : '0;
   assign gp2_prdata_o  = gp2_pready_o ? rdata_r : '0;
   assign gp1_pslverr_o = gp1_pready_o & err_r;
   assign gp2_pslverr_o = gp2_pready_o & err_r;

   a_one_host_ready: assert property (@(posedge aclk) disable iff (!rst_n_i)
      !(gp1_pready_o && gp2_pready_o));

   a_accel_addr_stable: assert property (@(posedge aclk) disable iff (!rst_n_i)
      accel_psel_o && !accel_pready_i |=> $stable(accel_paddr_o));

endmodule

`default_nettype wire

// ==== hdl/shell_bus_pkg.sv ====
`default_nettype none

package shell_bus_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // bus widths
   ////////////////////////////////////////////////////////////////////////////

   // accelerator bus and hp0 carry full 32-bit addresses
   localparam int ACCEL_ADDR_W = 32;
   localparam int DATA_W       = 32;

   // host ports arrive with their top bits already dropped
   localparam int GP1_ADDR_W   = 30;
   localparam int GP2_ADDR_W   = 28;

   ////////////////////////////////////////////////////////////////////////////
   // dram window and profiler
   ////////////////////////////////////////////////////////////////////////////

   // start of cached dram in the accelerator map
   localparam logic [ACCEL_ADDR_W-1:0] ACCEL_DRAM_BASE = 32'h8000_0000;

   // one profile bit per 8 MB region, index from address bits 29..23
   localparam int PROFILE_W     = 128;
   localparam int PROFILE_LSB   = 23;
   localparam int PROFILE_IDX_W = $clog2(PROFILE_W);

   // host arbiter phases on the accelerator bus
   typedef enum logic [1:0] {
      ARB_IDLE,
      ARB_SETUP,
      ARB_ACCESS,
      ARB_RESP
   } arb_state_e;

endpackage

`default_nettype wire

// ==== hdl/shell_csr.sv ====
`timescale 1ns/1ps
`default_nettype none

module shell_csr (
   input  wire                                    aclk,
   input  wire                                    rst_n_i,
   input  wire                                    gp0_psel_i,
   input  wire                                    gp0_penable_i,
   input  wire                                    gp0_pwrite_i,
   input  wire [shell_csr_pkg::CSR_ADDR_W-1:0]    gp0_paddr_i,
   input  wire [shell_bus_pkg::DATA_W-1:0]        gp0_pwdata_i,
   input  wire [shell_bus_pkg::PROFILE_W-1:0]     profile_i,
   output logic [shell_bus_pkg::DATA_W-1:0]       gp0_prdata_o,
   output logic                                   gp0_pready_o,
   output logic                                   gp0_pslverr_o,
   output logic                                   sys_reset_n_o,
   output logic                                   dram_init_o,
   output logic [shell_bus_pkg::ACCEL_ADDR_W-1:0] dram_base_o
);
   import shell_bus_pkg::*;
   import shell_csr_pkg::*;

   csr_reg_e                reg_sel;
   logic                    setup;
   logic                    wr_en;
   logic                    dec_err;
   logic [DATA_W-1:0]       rd_data;
   logic                    pready_r;
   logic                    pslverr_r;
   logic [DATA_W-1:0]       prdata_r;
   logic                    sys_reset_r;
   logic                    dram_init_r;
   logic [ACCEL_ADDR_W-1:0] dram_base_r;

   assign reg_sel = csr_reg_e'(gp0_paddr_i);
   assign setup   = gp0_psel_i & ~gp0_penable_i;

   // decode: profile words are read only, anything unlisted is an error
   always_comb begin
      rd_data = '0;
      dec_err = 1'b0;
      case (reg_sel)
         CSR_SYS_RESET: rd_data = DATA_W'(sys_reset_r);
         CSR_DRAM_INIT: rd_data = DATA_W'(dram_init_r);
         CSR_DRAM_BASE: rd_data = dram_base_r;
         CSR_PROFILE0: begin
            rd_data = profile_i[0*DATA_W +: DATA_W];
            dec_err = gp0_pwrite_i;
         end
         CSR_PROFILE1: begin
            rd_data = profile_i[1*DATA_W +: DATA_W];
            dec_err = gp0_pwrite_i;
         end
         CSR_PROFILE2: begin
            rd_data = profile_i[2*DATA_W +: DATA_W];
            dec_err = gp0_pwrite_i;
         end
         CSR_PROFILE3: begin
            rd_data = profile_i[3*DATA_W +: DATA_W];
            dec_err = gp0_pwrite_i;
         end
         default: dec_err = 1'b1;
      endcase
   end

   ////////////////////////////////////////////////////////////////////////////
   // response, staged in setup so the access phase has no wait state
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge aclk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         pready_r  <= 1'b0;
         pslverr_r <= 1'b0;
      end else begin
         pready_r  <= setup;
         pslverr_r <= setup & dec_err;
      end
   end

   always_ff @(posedge aclk) begin
      if (setup) begin
         prdata_r <= rd_data;
      end
   end

   assign gp0_pready_o  = pready_r;
   assign gp0_pslverr_o = pslverr_r;
   assign gp0_prdata_o  = prdata_r;

   // writes land on the completing edge
   assign wr_en = pready_r & gp0_pwrite_i & ~pslverr_r;

   always_ff @(posedge aclk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         sys_reset_r <= SYS_RESET_RST;
         dram_init_r <= DRAM_INIT_RST;
         dram_base_r <= DRAM_BASE_RST;
      end else if (wr_en) begin
         case (reg_sel)
            CSR_SYS_RESET: sys_reset_r <= gp0_pwdata_i[0];
            CSR_DRAM_INIT: dram_init_r <= gp0_pwdata_i[0];
            CSR_DRAM_BASE: dram_base_r <= gp0_pwdata_i;
            default: ;
         endcase
      end
   end

   assign sys_reset_n_o = sys_reset_r;
   assign dram_init_o   = dram_init_r;
   assign dram_base_o   = dram_base_r;

   // the requester has to hold the access phase until we complete it
   a_pready_in_access: assert property (@(posedge aclk) disable iff (!rst_n_i)
      gp0_pready_o |-> gp0_psel_i && gp0_penable_i);

endmodule

`default_nettype wire

// ==== hdl/shell_csr_pkg.sv ====
`default_nettype none

package shell_csr_pkg;

   // management port decodes 1 KB
   localparam int CSR_ADDR_W = 10;

   ////////////////////////////////////////////////////////////////////////////
   // register map
   ////////////////////////////////////////////////////////////////////////////

   typedef enum logic [CSR_ADDR_W-1:0] {
      // bit 0, active low accelerator reset
      CSR_SYS_RESET = 10'h000,
      // bit 0, set once the host has allocated dram
      CSR_DRAM_INIT = 10'h004,
      // physical base of the allocated dram
      CSR_DRAM_BASE = 10'h008,
      // memory profile, word 0 holds bits 31..0
      CSR_PROFILE0  = 10'h00C,
      CSR_PROFILE1  = 10'h010,
      CSR_PROFILE2  = 10'h014,
      CSR_PROFILE3  = 10'h018
   } csr_reg_e;

   // values after reset
   localparam logic        SYS_RESET_RST = 1'b0;
   localparam logic        DRAM_INIT_RST = 1'b0;
   localparam logic [31:0] DRAM_BASE_RST = 32'h0000_0000;

endpackage

`default_nettype wire

// ==== hdl/zynq_accel_shell.sv ====
`timescale 1ns/1ps
`default_nettype none

module zynq_accel_shell (
   input  wire                                    aclk,
   input  wire                                    rst_n_i,
   // gp0 management port
   input  wire                                    gp0_psel_i,
   input  wire                                    gp0_penable_i,
   input  wire                                    gp0_pwrite_i,
   input  wire [shell_csr_pkg::CSR_ADDR_W-1:0]    gp0_paddr_i,
   input  wire [shell_bus_pkg::DATA_W-1:0]        gp0_pwdata_i,
   output logic [shell_bus_pkg::DATA_W-1:0]       gp0_prdata_o,
   output logic                                   gp0_pready_o,
   output logic                                   gp0_pslverr_o,
   // gp1 host port
   input  wire                                    gp1_psel_i,
   input  wire                                    gp1_penable_i,
   input  wire                                    gp1_pwrite_i,
   input  wire [shell_bus_pkg::GP1_ADDR_W-1:0]    gp1_paddr_i,
   input  wire [shell_bus_pkg::DATA_W-1:0]        gp1_pwdata_i,
   output logic [shell_bus_pkg::DATA_W-1:0]       gp1_prdata_o,
   output logic                                   gp1_pready_o,
   output logic                                   gp1_pslverr_o,
   // gp2 host port
   input  wire                                    gp2_psel_i,
   input  wire                                    gp2_penable_i,
   input  wire                                    gp2_pwrite_i,
   input  wire [shell_bus_pkg::GP2_ADDR_W-1:0]    gp2_paddr_i,
   input  wire [shell_bus_pkg::DATA_W-1:0]        gp2_pwdata_i,
   output logic [shell_bus_pkg::DATA_W-1:0]       gp2_prdata_o,
   output logic                                   gp2_pready_o,
   output logic                                   gp2_pslverr_o,
   // accelerator bus
   output logic                                   accel_psel_o,
   output logic                                   accel_penable_o,
   output logic                                   accel_pwrite_o,
   output logic [shell_bus_pkg::ACCEL_ADDR_W-1:0] accel_paddr_o,
   output logic [shell_bus_pkg::DATA_W-1:0]       accel_pwdata_o,
   input  wire [shell_bus_pkg::DATA_W-1:0]        accel_prdata_i,
   input  wire                                    accel_pready_i,
   input  wire                                    accel_pslverr_i,
   // accelerator dram requests
   input  wire                                    dram_psel_i,
   input  wire                                    dram_penable_i,
   input  wire                                    dram_pwrite_i,
   input  wire [shell_bus_pkg::ACCEL_ADDR_W-1:0]  dram_paddr_i,
   input  wire [shell_bus_pkg::DATA_W-1:0]        dram_pwdata_i,
   output logic [shell_bus_pkg::DATA_W-1:0]       dram_prdata_o,
   output logic                                   dram_pready_o,
   output logic                                   dram_pslverr_o,
   // hp0 dram port
   output logic                                   hp0_psel_o,
   output logic                                   hp0_penable_o,
   output logic                                   hp0_pwrite_o,
   output logic [shell_bus_pkg::ACCEL_ADDR_W-1:0] hp0_paddr_o,
   output logic [shell_bus_pkg::DATA_W-1:0]       hp0_pwdata_o,
   input  wire [shell_bus_pkg::DATA_W-1:0]        hp0_prdata_i,
   input  wire                                    hp0_pready_i,
   input  wire                                    hp0_pslverr_i,
   output logic                                   accel_rst_n_o
);
   import shell_bus_pkg::*;

   logic                    sys_reset_n;
   logic                    dram_init;
   logic [ACCEL_ADDR_W-1:0] dram_base;
   logic [PROFILE_W-1:0]    profile;

   // accelerator held in reset until the host releases it
   assign accel_rst_n_o = rst_n_i & sys_reset_n;

   // bus ports share names with the top, only the side signals are listed
   shell_csr u_csr (
      .*,
      .profile_i     (profile),
      .sys_reset_n_o (sys_reset_n),
      .dram_init_o   (dram_init),
      .dram_base_o   (dram_base)
   );

   host_apb_arbiter u_arb (
      .*
   );

   dram_window u_dram (
      .*,
      .accel_rst_n_i (accel_rst_n_o),
      .dram_init_i   (dram_init),
      .dram_base_i   (dram_base),
      .profile_o     (profile)
   );

endmodule

`default_nettype wire

// ==== sim/tb_clkgen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
   output logic aclk_o,
   output logic rst_n_o
);
   // 40 ns period
   localparam int HALF_PERIOD_NS = 20;
   localparam int RESET_CYCLES   = 3;

   initial begin
      aclk_o = 1'b0;
      forever begin
         #HALF_PERIOD_NS;
         aclk_o = ~aclk_o;
      end
   end

   // reset released just after the third rising edge
   initial begin
      rst_n_o = 1'b0;
      repeat (RESET_CYCLES) @(posedge aclk_o);
      #1;
      rst_n_o = 1'b1;
   end

endmodule

`default_nettype wire

// ==== sim/tb_zynq_accel_shell.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_zynq_accel_shell;
   import shell_bus_pkg::*;
   import shell_csr_pkg::*;

   localparam int          DRIVE_DLY  = 1;
   localparam int          MAX_WAIT   = 64;
   localparam int          GP0        = 0;
   localparam int          GP1        = 1;
   localparam int          GP2        = 2;
   localparam int          DRAM       = 3;
   localparam int          MAP_GP1    = 0;
   localparam int          MAP_GP2    = 1;
   localparam int          MAP_DRAM   = 2;
   localparam int          MAP_REGION = 3;
   localparam logic [31:0] RD_MASK    = 32'h5A5A_5A5A;

   logic             aclk;
   logic             rst_n_i;
   integer           seed = 32'hff3a;
   // requester side of the gp0, gp1, gp2 and dram ports indexed by port number
   logic [3:0]       psel;
   logic [3:0]       penable;
   logic [3:0]       pwrite;
   logic [3:0][31:0] paddr;
   logic [3:0][31:0] pwdata;
   wire  [3:0][31:0] prdata;
   wire  [3:0]       pready;
   wire  [3:0]       pslverr;
   wire              accel_psel_o;
   wire              accel_penable_o;
   wire              accel_pwrite_o;
   wire  [31:0]      accel_paddr_o;
   wire  [31:0]      accel_pwdata_o;
   logic [31:0]      accel_prdata_i;
   logic             accel_pready_i;
   logic             accel_pslverr_i;
   wire              hp0_psel_o;
   wire              hp0_penable_o;
   wire              hp0_pwrite_o;
   wire  [31:0]      hp0_paddr_o;
   wire  [31:0]      hp0_pwdata_o;
   wire  [31:0]      hp0_prdata_i;
   wire              hp0_pready_i;
   wire              hp0_pslverr_i;
   wire              accel_rst_n_o;
   logic [31:0]      accel_seen[$];
   logic             accel_wr_seen[$];
   logic [31:0]      accel_wdata_seen[$];
   logic [31:0]      hp0_seen[$];
   logic             hp0_wr_seen[$];
   logic [31:0]      hp0_wdata_seen[$];

   tb_clkgen u_clk (
      .aclk_o  (aclk),
      .rst_n_o (rst_n_i)
   );

   zynq_accel_shell u_dut (
      .*,
      .gp0_psel_i     (psel[GP0]),
      .gp0_penable_i  (penable[GP0]),
      .gp0_pwrite_i   (pwrite[GP0]),
      .gp0_paddr_i    (paddr[GP0][CSR_ADDR_W-1:0]),
      .gp0_pwdata_i   (pwdata[GP0]),
      .gp0_prdata_o   (prdata[GP0]),
      .gp0_pready_o   (pready[GP0]),
      .gp0_pslverr_o  (pslverr[GP0]),
      .gp1_psel_i     (psel[GP1]),
      .gp1_penable_i  (penable[GP1]),
      .gp1_pwrite_i   (pwrite[GP1]),
      .gp1_paddr_i    (paddr[GP1][GP1_ADDR_W-1:0]),
      .gp1_pwdata_i   (pwdata[GP1]),
      .gp1_prdata_o   (prdata[GP1]),
      .gp1_pready_o   (pready[GP1]),
      .gp1_pslverr_o  (pslverr[GP1]),
      .gp2_psel_i     (psel[GP2]),
      .gp2_penable_i  (penable[GP2]),
      .gp2_pwrite_i   (pwrite[GP2]),
      .gp2_paddr_i    (paddr[GP2][GP2_ADDR_W-1:0]),
      .gp2_pwdata_i   (pwdata[GP2]),
      .gp2_prdata_o   (prdata[GP2]),
      .gp2_pready_o   (pready[GP2]),
      .gp2_pslverr_o  (pslverr[GP2]),
      .dram_psel_i    (psel[DRAM]),
      .dram_penable_i (penable[DRAM]),
      .dram_pwrite_i  (pwrite[DRAM]),
      .dram_paddr_i   (paddr[DRAM]),
      .dram_pwdata_i  (pwdata[DRAM]),
      .dram_prdata_o  (prdata[DRAM]),
      .dram_pready_o  (pready[DRAM]),
      .dram_pslverr_o (pslverr[DRAM])
   );

   ////////////////////////////////////////////////////////////////////////////
   // external models
   ////////////////////////////////////////////////////////////////////////////

   // accelerator target adds 0 to 3 wait states and answers reads with the masked address
   initial begin : accel_model
      int unsigned waits;
      accel_prdata_i  = '0;
      accel_pready_i  = 1'b0;
      accel_pslverr_i = 1'b0;
      forever begin
         @(posedge aclk);
         #DRIVE_DLY;
         if (accel_psel_o && !accel_penable_o) begin
            accel_seen.push_back(accel_paddr_o);
            accel_wr_seen.push_back(accel_pwrite_o);
            accel_wdata_seen.push_back(accel_pwdata_o);
            waits = $unsigned($random(seed)) % 4;
            repeat (waits + 1) begin
               @(posedge aclk);
               #DRIVE_DLY;
            end
            accel_prdata_i = accel_paddr_o ^ RD_MASK;
            accel_pready_i = 1'b1;
            @(posedge aclk);
            #DRIVE_DLY;
            accel_pready_i = 1'b0;
         end
      end
   end

   // hp0 memory answers at once and returns the inverted address on reads
   assign hp0_pready_i  = hp0_psel_o & hp0_penable_o;
   assign hp0_prdata_i  = ~hp0_paddr_o;
   assign hp0_pslverr_i = 1'b0;

   always @(negedge aclk) begin
      if (hp0_psel_o && hp0_penable_o && hp0_pready_i) begin
         hp0_seen.push_back(hp0_paddr_o);
         hp0_wr_seen.push_back(hp0_pwrite_o);
         hp0_wdata_seen.push_back(hp0_pwdata_o);
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // reference and checks
   ////////////////////////////////////////////////////////////////////////////

   // expected address behind each path or the profile region of a dram address
   function automatic logic [31:0] map_address(input int path, input logic [31:0] addr,
                                               input logic [31:0] base);
      case (path)
         MAP_GP1:  map_address = {~addr[29], 3'b000, addr[27:0]};
         MAP_GP2:  map_address = {4'h0, addr[27:0]};
         MAP_DRAM: map_address = (addr ^ 32'h8000_0000) + base;
         default:  map_address = {25'd0, addr[29:23]};
      endcase
   endfunction

   task automatic check_value(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         $display("ERROR at %0d ns: %s is %h, expected %h", $time, what, got, exp);
         $display("Regression failed");
         $fatal(1, "mismatch");
      end
   endtask

   task automatic abort_wait(input string what);
      $display("timeout while waiting for %s", what);
      $display("Regression failed");
      $fatal(1, "timeout");
   endtask

   // one apb transfer with outputs sampled on the falling edge
   task automatic apb_xfer(input int port, input logic wr, input logic [31:0] addr,
                           input logic [31:0] wdata, output logic [31:0] rdata,
                           output logic err);
      int n;
      @(posedge aclk);
      #DRIVE_DLY;
      psel[port]   = 1'b1;
      pwrite[port] = wr;
      paddr[port]  = addr;
      pwdata[port] = wdata;
      @(posedge aclk);
      #DRIVE_DLY;
      penable[port] = 1'b1;
      n = 0;
      @(negedge aclk);
      while (!pready[port]) begin
         n++;
         if (n > MAX_WAIT) begin
            abort_wait("pready on a host or dram port");
         end
         @(negedge aclk);
      end
      rdata = prdata[port];
      err   = pslverr[port];
      @(posedge aclk);
      #DRIVE_DLY;
      psel[port]    = 1'b0;
      penable[port] = 1'b0;
   endtask

   task automatic csr_write(input logic [9:0] offs, input logic [31:0] data,
                            input logic exp_err);
      logic [31:0] rd;
      logic        err;
      apb_xfer(GP0, 1'b1, offs, data, rd, err);
      check_value("gp0 write pslverr", err, exp_err);
   endtask

   task automatic csr_expect(input logic [9:0] offs, input logic [31:0] exp);
      logic [31:0] rd;
      logic        err;
      apb_xfer(GP0, 1'b0, offs, '0, rd, err);
      check_value("gp0 read pslverr", err, 1'b0);
      check_value("gp0 read data", rd, exp);
   endtask

   task automatic expect_accel(input string what, input logic [31:0] exp_addr,
                               input logic exp_wr, input logic [31:0] exp_wdata);
      logic [31:0] wdata;
      check_value({what, " reached the accelerator"}, accel_seen.size() != 0, 1'b1);
      check_value({what, " accelerator address"}, accel_seen.pop_front(), exp_addr);
      check_value({what, " accelerator pwrite"}, accel_wr_seen.pop_front(), exp_wr);
      wdata = accel_wdata_seen.pop_front();
      if (exp_wr) begin
         check_value({what, " accelerator pwdata"}, wdata, exp_wdata);
      end
   endtask

   initial begin : stimulus
      int                   n;
      logic [31:0]          a1;
      logic [31:0]          a2;
      logic [31:0]          rd1;
      logic [31:0]          rd2;
      logic [31:0]          wd;
      logic [31:0]          wd_seen;
      logic [31:0]          base;
      logic [31:0]          exp_a;
      logic                 e1;
      logic                 e2;
      logic                 wr;
      logic [PROFILE_W-1:0] exp_profile;
      psel    = '0;
      penable = '0;
      pwrite  = '0;
      paddr   = '0;
      pwdata  = '0;
      n = 0;
      while (rst_n_i !== 1'b1) begin
         n++;
         if (n > MAX_WAIT) begin
            abort_wait("reset release");
         end
         @(posedge aclk);
      end

      // reset values
      check_value("accel_rst_n_o after reset", accel_rst_n_o, 1'b0);
      check_value("bus handshake outputs after reset",
                  {pready, accel_psel_o, accel_penable_o, hp0_psel_o, hp0_penable_o}, '0);
      csr_expect(CSR_SYS_RESET, 0);
      csr_expect(CSR_DRAM_INIT, 0);
      csr_expect(CSR_DRAM_BASE, 0);
      for (int i = 0; i < 4; i++) begin
         csr_expect(CSR_PROFILE0 + 4 * i, 0);
      end

      // register writes and then error responses that must change nothing
      base = $random(seed);
      csr_write(CSR_DRAM_BASE, base, 1'b0);
      csr_write(CSR_DRAM_INIT, 1, 1'b0);
      csr_write(CSR_SYS_RESET, 1, 1'b0);
      check_value("accel_rst_n_o after release", accel_rst_n_o, 1'b1);
      apb_xfer(GP0, 1'b0, 10'h3FC, '0, rd1, e1);
      check_value("unmapped read pslverr", e1, 1'b1);
      csr_write(CSR_PROFILE0, 32'hFFFF_FFFF, 1'b1);
      csr_expect(CSR_DRAM_BASE, base);
      csr_expect(CSR_DRAM_INIT, 1);
      csr_expect(CSR_SYS_RESET, 1);
      csr_expect(CSR_PROFILE0, 0);

      // single host transfers through the translation
      for (int i = 0; i < 8; i++) begin
         a1 = $random(seed);
         wr = $random(seed);
         wd = $random(seed);
         apb_xfer(GP1, wr, a1[29:0], wd, rd1, e1);
         exp_a = map_address(MAP_GP1, a1, 0);
         expect_accel("gp1", exp_a, wr, wd);
         check_value("gp1 pslverr", e1, 1'b0);
         if (!wr) begin
            check_value("gp1 read data", rd1, exp_a ^ RD_MASK);
         end
         a2 = $random(seed);
         wr = $random(seed);
         wd = $random(seed);
         apb_xfer(GP2, wr, a2[27:0], wd, rd2, e2);
         exp_a = map_address(MAP_GP2, a2, 0);
         expect_accel("gp2", exp_a, wr, wd);
         check_value("gp2 pslverr", e2, 1'b0);
         if (!wr) begin
            check_value("gp2 read data", rd2, exp_a ^ RD_MASK);
         end
      end

      // gp2 was served last, so every tie goes to gp1 first
      for (int i = 0; i < 3; i++) begin
         a1 = $random(seed);
         a2 = $random(seed);
         fork
            apb_xfer(GP1, 1'b0, a1[29:0], '0, rd1, e1);
            apb_xfer(GP2, 1'b0, a2[27:0], '0, rd2, e2);
         join
         expect_accel("paired gp1", map_address(MAP_GP1, a1, 0), 1'b0, '0);
         expect_accel("paired gp2", map_address(MAP_GP2, a2, 0), 1'b0, '0);
         check_value("paired gp1 data", rd1, map_address(MAP_GP1, a1, 0) ^ RD_MASK);
         check_value("paired gp2 data", rd2, map_address(MAP_GP2, a2, 0) ^ RD_MASK);
      end
      check_value("extra accelerator requests", accel_seen.size(), 0);

      // dram window without an allocation first
      csr_write(CSR_DRAM_INIT, 0, 1'b0);
      apb_xfer(DRAM, 1'b0, 32'h8000_0040, '0, rd1, e1);
      check_value("unallocated dram pslverr", e1, 1'b1);
      check_value("unallocated hp0 requests", hp0_seen.size(), 0);
      base = $random(seed);
      csr_write(CSR_DRAM_BASE, base, 1'b0);
      csr_write(CSR_DRAM_INIT, 1, 1'b0);
      exp_profile = '0;
      for (int i = 0; i < 12; i++) begin
         a1        = $random(seed);
         a1[31:30] = 2'b10;
         wr        = $random(seed);
         apb_xfer(DRAM, wr, a1, ~a1, rd1, e1);
         exp_a = map_address(MAP_DRAM, a1, base);
         check_value("hp0 request count", hp0_seen.size(), 1);
         check_value("hp0 address", hp0_seen.pop_front(), exp_a);
         check_value("hp0 pwrite", hp0_wr_seen.pop_front(), wr);
         wd_seen = hp0_wdata_seen.pop_front();
         if (wr) begin
            check_value("hp0 pwdata", wd_seen, ~a1);
         end
         check_value("dram pslverr", e1, 1'b0);
         if (!wr) begin
            check_value("dram read data", rd1, ~exp_a);
         end
         exp_profile[map_address(MAP_REGION, a1, 0)] = 1'b1;
      end
      for (int i = 0; i < 4; i++) begin
         csr_expect(CSR_PROFILE0 + 4 * i, exp_profile[32 * i +: 32]);
      end

      // accelerator reset clears the profile
      csr_write(CSR_SYS_RESET, 0, 1'b0);
      check_value("accel_rst_n_o after hold", accel_rst_n_o, 1'b0);
      for (int i = 0; i < 4; i++) begin
         csr_expect(CSR_PROFILE0 + 4 * i, 0);
      end

      $display("Regression passed");
      $finish;
   end

endmodule

`default_nettype wire
